//--- design/dcache_pkg.sv
package dcache_pkg;

  // data and address width
  localparam int XLEN = 32;
  localparam int LANES = XLEN / 8;

  // cache geometry, direct mapped
  localparam int LINE_WORDS = 4;
  localparam int INDEX_BITS = 8;
  localparam int WORD_OFF_BITS = 2;
  localparam int TAG_BITS = 17;
  localparam int NUM_LINES = 1 << INDEX_BITS;
  localparam int NUM_WORDS = NUM_LINES * LINE_WORDS;

  // word address as seen on the bus, address bits 28:2
  localparam int BUS_ADDR_BITS = 27;

  // field positions inside a byte address
  localparam int INDEX_LSB = 4;
  localparam int TAG_LSB = INDEX_LSB + INDEX_BITS;
  // bits above the tag are ignored
  localparam int TAG_MSB = TAG_LSB + TAG_BITS - 1;

  // access width codes
  localparam logic [1:0] WIDTH_BYTE = 2'd0;
  localparam logic [1:0] WIDTH_HALF = 2'd1;
  localparam logic [1:0] WIDTH_WORD = 2'd2;

  // fault causes reported with resp_error
  localparam logic [3:0] CAUSE_NONE = 4'd0;
  localparam logic [3:0] CAUSE_LOAD_FAULT = 4'd5;
  localparam logic [3:0] CAUSE_STORE_FAULT = 4'd7;

endpackage

//--- design/lane_align.sv
`timescale 1ns/1ps

module lane_align import dcache_pkg::*; (
  input  logic [1:0]      width,
  input  logic            extend,
  input  logic [1:0]      byte_off,
  input  logic [XLEN-1:0] store_data,
  output logic [XLEN-1:0] lane_data,
  output logic [3:0]      lane_mask,
  input  logic [XLEN-1:0] word_in,
  output logic [XLEN-1:0] load_data
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // store side, move low bits of the store data into their lanes
  always_comb begin
    lane_data = '0;
    lane_mask = '0;
    case (width)
      WIDTH_BYTE: begin
        lane_data[byte_off*8 +: 8] = store_data[7:0];
        lane_mask[byte_off] = 1'b1;
      end
      WIDTH_HALF: begin
        lane_data[byte_off[1]*16 +: 16] = store_data[15:0];
        lane_mask[byte_off[1]*2 +: 2] = 2'b11;
      end
      default: begin
        lane_data = store_data;
        lane_mask = {LANES{1'b1}};
      end
    endcase
  end

  // load side
  assign sel_byte = word_in[byte_off*8 +: 8];
  assign sel_half = word_in[byte_off[1]*16 +: 16];

  always_comb begin
    case (width)
      WIDTH_BYTE: load_data = {{(XLEN-8){extend & sel_byte[7]}}, sel_byte};
      WIDTH_HALF: load_data = {{(XLEN-16){extend & sel_half[15]}}, sel_half};
      WIDTH_WORD: load_data = word_in;
      // unused code, treat as a word
      default: load_data = word_in;
    endcase
  end

endmodule

//--- design/dcache_array.sv
`timescale 1ns/1ps

module dcache_array import dcache_pkg::*; (
  input  logic                                clk_core,
  input  logic                                reset_n,

  // read port, combinational
  input  logic [INDEX_BITS+WORD_OFF_BITS-1:0] rd_index,
  output logic [TAG_BITS-1:0]                 rd_tag,
  output logic                                rd_valid,
  output logic                                rd_dirty,
  output logic [XLEN-1:0]                     rd_data,

  // write port
  input  logic [INDEX_BITS+WORD_OFF_BITS-1:0] wr_index,
  input  logic                                wr_data_en,
  input  logic [XLEN-1:0]                     wr_data,
  input  logic [3:0]                          wr_mask,
  input  logic                                wr_meta_en,
  input  logic [TAG_BITS-1:0]                 wr_tag,
  input  logic                                wr_valid,
  input  logic                                wr_dirty
);

  logic [XLEN-1:0]     data_mem [NUM_WORDS];
  logic [TAG_BITS-1:0] tag_mem  [NUM_LINES];
  logic [NUM_LINES-1:0] valid_bits;
  logic [NUM_LINES-1:0] dirty_bits;

  logic [INDEX_BITS-1:0] rd_line;
  logic [INDEX_BITS-1:0] wr_line;

  // line index is the upper part of the word index
  assign rd_line = rd_index[INDEX_BITS+WORD_OFF_BITS-1:WORD_OFF_BITS];
  assign wr_line = wr_index[INDEX_BITS+WORD_OFF_BITS-1:WORD_OFF_BITS];

  assign rd_data  = data_mem[rd_index];
  assign rd_tag   = tag_mem[rd_line];
  assign rd_valid = valid_bits[rd_line];
  assign rd_dirty = dirty_bits[rd_line];

  // byte masked data write
  always_ff @(posedge clk_core) begin
    if (wr_data_en) begin
      for (int b = 0; b < LANES; b++) begin
        if (wr_mask[b]) begin
          data_mem[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_core) begin
    if (wr_meta_en) begin
      tag_mem[wr_line] <= wr_tag;
    end
  end

  always_ff @(posedge clk_core) begin
    if (!reset_n) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (wr_meta_en) begin
      valid_bits[wr_line] <= wr_valid;
      dirty_bits[wr_line] <= wr_dirty;
    end
  end

endmodule

//--- design/refill_ctrl.sv
`timescale 1ns/1ps

module refill_ctrl import dcache_pkg::*; (
  input  logic                                clk_core,
  input  logic                                reset_n,

  // held request
  input  logic                                active,
  input  logic                                write,
  input  logic [XLEN-1:0]                     addr,
  input  logic [XLEN-1:0]                     lane_data,
  input  logic [3:0]                          lane_mask,
  input  logic                                resp_fire,

  // cache array
  input  logic [TAG_BITS-1:0]                 arr_tag,
  input  logic                                arr_valid,
  input  logic                                arr_dirty,
  input  logic [XLEN-1:0]                     arr_data,
  output logic [INDEX_BITS+WORD_OFF_BITS-1:0] arr_index,
  output logic                                arr_wr_data_en,
  output logic [XLEN-1:0]                     arr_wr_data,
  output logic [3:0]                          arr_wr_mask,
  output logic                                arr_wr_meta_en,
  output logic [TAG_BITS-1:0]                 arr_wr_tag,
  output logic                                arr_wr_valid,
  output logic                                arr_wr_dirty,

  // result
  output logic                                use_fill_word,
  output logic [XLEN-1:0]                     fill_word,
  output logic                                done,
  output logic                                error,

  // bus
  output logic                                cvalid,
  input  logic                                cready,
  output logic                                cmd,
  output logic [BUS_ADDR_BITS-1:0]            bus_addr,
  output logic                                wvalid,
  input  logic                                wready,
  output logic                                wlast,
  output logic [XLEN-1:0]                     wdata,
  input  logic                                rvalid,
  output logic                                rready,
  input  logic                                rlast,
  input  logic [XLEN-1:0]                     rdata,
  input  logic                                bus_error,
  output logic                                eack
);

  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_EVICT    = 3'd1;
  localparam logic [2:0] ST_FILL_CMD = 3'd2;
  localparam logic [2:0] ST_FILL     = 3'd3;
  localparam logic [2:0] ST_COMMIT   = 3'd4;
  localparam logic [2:0] ST_ISSUE    = 3'd5;

  logic [2:0]               state;
  logic [2:0]               state_next;
  logic [WORD_OFF_BITS-1:0] offset;
  logic                     cmd_sent;
  logic                     err_flag;

  logic [TAG_BITS-1:0]      req_tag;
  logic [INDEX_BITS-1:0]    req_line;
  logic [WORD_OFF_BITS-1:0] req_word;
  logic                     hit;
  logic                     w_beat;
  logic                     r_beat;

  assign req_tag  = addr[TAG_MSB:TAG_LSB];
  assign req_line = addr[TAG_LSB-1:INDEX_LSB];
  assign req_word = addr[INDEX_LSB-1:2];

  assign hit    = arr_valid & (arr_tag == req_tag);
  assign w_beat = wvalid & wready;
  assign r_beat = rvalid & rready;
  assign eack   = bus_error;

  // an error ends any burst at once
  always_ff @(posedge clk_core) begin
    if (!reset_n) begin
      state <= ST_IDLE;
    end else if (bus_error) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // beat counter inside the line, wraps after the last beat
  always_ff @(posedge clk_core) begin
    if (!reset_n || bus_error) begin
      offset <= '0;
    end else if (w_beat || r_beat) begin
      offset <= offset + 1'b1;
    end
  end

  // write command goes out before the first data beat
  always_ff @(posedge clk_core) begin
    if (!reset_n || bus_error || state != ST_EVICT) begin
      cmd_sent <= 1'b0;
    end else if (cvalid && cready) begin
      cmd_sent <= 1'b1;
    end
  end

  always_ff @(posedge clk_core) begin
    if (!reset_n) begin
      err_flag <= 1'b0;
    end else if (bus_error) begin
      err_flag <= 1'b1;
    end else if (resp_fire) begin
      err_flag <= 1'b0;
    end
  end

  // requested word as it arrives from the bus
  always_ff @(posedge clk_core) begin
    if (state == ST_FILL && r_beat && offset == req_word) begin
      fill_word <= rdata;
    end
  end

  always_comb begin
    state_next     = state;
    arr_index      = {req_line, req_word};
    arr_wr_data_en = 1'b0;
    arr_wr_data    = lane_data;
    arr_wr_mask    = lane_mask;
    arr_wr_meta_en = 1'b0;
    arr_wr_tag     = req_tag;
    arr_wr_valid   = 1'b1;
    arr_wr_dirty   = 1'b1;
    use_fill_word  = 1'b0;
    done           = 1'b0;
    error          = 1'b0;
    cvalid         = 1'b0;
    cmd            = 1'b1;
    bus_addr       = {req_tag, req_line, {WORD_OFF_BITS{1'b0}}};
    wvalid         = 1'b0;
    wlast          = 1'b0;
    wdata          = arr_data;
    rready         = 1'b0;

    case (state)
      ST_IDLE: begin
        if (active) begin
          if (err_flag) begin
            done  = 1'b1;
            error = 1'b1;
          end else if (hit) begin
            done = 1'b1;
            // store hit lands when the response is taken
            if (write && resp_fire) begin
              arr_wr_data_en = 1'b1;
              arr_wr_meta_en = 1'b1;
            end
          end else if (arr_valid && arr_dirty) begin
            state_next = ST_EVICT;
          end else begin
            state_next = ST_FILL_CMD;
          end
        end
      end

      ST_EVICT: begin
        arr_index = {req_line, offset};
        cmd       = 1'b0;
        bus_addr  = {arr_tag, req_line, {WORD_OFF_BITS{1'b0}}};
        cvalid    = ~cmd_sent;
        wvalid    = cmd_sent;
        wlast     = offset == WORD_OFF_BITS'(LINE_WORDS - 1);
        if (w_beat && wlast) begin
          state_next = ST_FILL_CMD;
        end
      end

      ST_FILL_CMD: begin
        cvalid = 1'b1;
        // line is invalid until the burst completes
        arr_wr_meta_en = 1'b1;
        arr_wr_valid   = 1'b0;
        arr_wr_dirty   = 1'b0;
        if (cready) begin
          state_next = ST_FILL;
        end
      end

      ST_FILL: begin
        arr_index      = {req_line, offset};
        rready         = 1'b1;
        arr_wr_data    = rdata;
        arr_wr_mask    = {LANES{1'b1}};
        arr_wr_data_en = r_beat;
        if (r_beat && rlast) begin
          arr_wr_meta_en = 1'b1;
          arr_wr_dirty   = 1'b0;
          state_next     = ST_COMMIT;
        end
      end

      ST_COMMIT: begin
        if (write) begin
          arr_wr_data_en = 1'b1;
          arr_wr_meta_en = 1'b1;
        end
        state_next = ST_ISSUE;
      end

      ST_ISSUE: begin
        use_fill_word = 1'b1;
        done          = 1'b1;
        if (resp_fire) begin
          state_next = ST_IDLE;
        end
      end

      default: state_next = ST_IDLE;
    endcase
  end

endmodule

//--- design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import dcache_pkg::*; (
  input  logic                     clk_core,
  input  logic                     reset_n,

  // request
  input  logic                     req_valid,
  output logic                     req_ready,
  input  logic                     req_write,
  input  logic                     req_extend,
  input  logic [1:0]               req_width,
  input  logic [XLEN-1:0]          req_addr,
  input  logic [XLEN-1:0]          req_wdata,

  // response
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output logic [XLEN-1:0]          resp_rdata,
  output logic                     resp_error,
  output logic [3:0]               resp_cause,

  // bus
  output logic                     cvalid,
  input  logic                     cready,
  output logic                     cmd,
  output logic [BUS_ADDR_BITS-1:0] bus_addr,
  output logic                     wvalid,
  input  logic                     wready,
  output logic                     wlast,
  output logic [XLEN-1:0]          wdata,
  input  logic                     rvalid,
  output logic                     rready,
  input  logic                     rlast,
  input  logic [XLEN-1:0]          rdata,
  input  logic                     bus_error,
  output logic                     eack
);

  logic                                full;
  logic                                write_q;
  logic                                extend_q;
  logic [1:0]                          width_q;
  logic [XLEN-1:0]                     addr_q;
  logic [XLEN-1:0]                     wdata_q;

  logic                                resp_fire;
  logic [XLEN-1:0]                     lane_data;
  logic [3:0]                          lane_mask;
  logic [XLEN-1:0]                     word_sel;

  logic [INDEX_BITS+WORD_OFF_BITS-1:0] arr_index;
  logic [TAG_BITS-1:0]                 arr_tag;
  logic                                arr_valid;
  logic                                arr_dirty;
  logic [XLEN-1:0]                     arr_data;
  logic                                arr_wr_data_en;
  logic [XLEN-1:0]                     arr_wr_data;
  logic [3:0]                          arr_wr_mask;
  logic                                arr_wr_meta_en;
  logic [TAG_BITS-1:0]                 arr_wr_tag;
  logic                                arr_wr_valid;
  logic                                arr_wr_dirty;

  logic                                use_fill_word;
  logic [XLEN-1:0]                     fill_word;
  logic                                done;
  logic                                error;

  assign req_ready = ~full;
  assign resp_fire = resp_valid & resp_ready;

  // one request in flight
  always_ff @(posedge clk_core) begin
    if (!reset_n) begin
      full <= 1'b0;
    end else if (req_valid && req_ready) begin
      full <= 1'b1;
    end else if (resp_fire) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk_core) begin
    if (req_valid && req_ready) begin
      write_q  <= req_write;
      extend_q <= req_extend;
      width_q  <= req_width;
      addr_q   <= req_addr;
      wdata_q  <= req_wdata;
    end
  end

  assign resp_valid = done;
  assign resp_error = error;
  assign resp_cause = !error ? CAUSE_NONE : write_q ? CAUSE_STORE_FAULT : CAUSE_LOAD_FAULT;

  // after a fill the word comes from the capture register
  assign word_sel = use_fill_word ? fill_word : arr_data;

  lane_align lane_align_i (
    .width      (width_q),
    .extend     (extend_q),
    .byte_off   (addr_q[1:0]),
    .store_data (wdata_q),
    .lane_data  (lane_data),
    .lane_mask  (lane_mask),
    .word_in    (word_sel),
    .load_data  (resp_rdata)
  );

  dcache_array dcache_array_i (
    .clk_core   (clk_core),
    .reset_n    (reset_n),
    .rd_index   (arr_index),
    .rd_tag     (arr_tag),
    .rd_valid   (arr_valid),
    .rd_dirty   (arr_dirty),
    .rd_data    (arr_data),
    .wr_index   (arr_index),
    .wr_data_en (arr_wr_data_en),
    .wr_data    (arr_wr_data),
    .wr_mask    (arr_wr_mask),
    .wr_meta_en (arr_wr_meta_en),
    .wr_tag     (arr_wr_tag),
    .wr_valid   (arr_wr_valid),
    .wr_dirty   (arr_wr_dirty)
  );

  refill_ctrl refill_ctrl_i (
    .clk_core       (clk_core),
    .reset_n        (reset_n),
    .active         (full),
    .write          (write_q),
    .addr           (addr_q),
    .lane_data      (lane_data),
    .lane_mask      (lane_mask),
    .resp_fire      (resp_fire),
    .arr_tag        (arr_tag),
    .arr_valid      (arr_valid),
    .arr_dirty      (arr_dirty),
    .arr_data       (arr_data),
    .arr_index      (arr_index),
    .arr_wr_data_en (arr_wr_data_en),
    .arr_wr_data    (arr_wr_data),
    .arr_wr_mask    (arr_wr_mask),
    .arr_wr_meta_en (arr_wr_meta_en),
    .arr_wr_tag     (arr_wr_tag),
    .arr_wr_valid   (arr_wr_valid),
    .arr_wr_dirty   (arr_wr_dirty),
    .use_fill_word  (use_fill_word),
    .fill_word      (fill_word),
    .done           (done),
    .error          (error),
    .cvalid         (cvalid),
    .cready         (cready),
    .cmd            (cmd),
    .bus_addr       (bus_addr),
    .wvalid         (wvalid),
    .wready         (wready),
    .wlast          (wlast),
    .wdata          (wdata),
    .rvalid         (rvalid),
    .rready         (rready),
    .rlast          (rlast),
    .rdata          (rdata),
    .bus_error      (bus_error),
    .eack           (eack)
  );

endmodule

//--- verif/bus_mem_model.sv
`timescale 1ns/1ps

module bus_mem_model import dcache_pkg::*; (
  input  logic                     clk_core,
  input  logic                     reset_n,
  input  logic                     err_en,
  input  logic [BUS_ADDR_BITS-1:0] err_lo,
  input  logic [BUS_ADDR_BITS-1:0] err_hi,
  input  logic                     cvalid,
  output logic                     cready,
  input  logic                     cmd,
  input  logic [BUS_ADDR_BITS-1:0] bus_addr,
  input  logic                     wvalid,
  output logic                     wready,
  input  logic [XLEN-1:0]          wdata,
  output logic                     rvalid,
  input  logic                     rready,
  output logic                     rlast,
  output logic [XLEN-1:0]          rdata,
  output logic                     bus_error
);

  localparam int MEM_WORDS = 16384;
  localparam logic [1:0] PH_IDLE  = 2'd0;
  localparam logic [1:0] PH_WRITE = 2'd1;
  localparam logic [1:0] PH_READ  = 2'd2;

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [1:0]      phase;
  logic [13:0]     base;
  logic [1:0]      beat;
  logic            inject;

  // each word starts as its byte address xor a fixed pattern
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'(i * 4) ^ 32'ha5a5a5a5;
    end
    phase     = PH_IDLE;
    base      = '0;
    beat      = '0;
    inject    = 1'b0;
    cready    = 1'b0;
    wready    = 1'b0;
    rvalid    = 1'b0;
    rlast     = 1'b0;
    rdata     = '0;
    bus_error = 1'b0;
  end

  always begin
    @(posedge clk_core);
    if (!reset_n) begin
      phase  = PH_IDLE;
      inject = 1'b0;
    end else if (phase == PH_IDLE) begin
      if (cvalid && cready) begin
        base   = bus_addr[13:0];
        beat   = '0;
        phase  = cmd ? PH_READ : PH_WRITE;
        inject = err_en && bus_addr >= err_lo && bus_addr <= err_hi;
      end
    end else if (bus_error) begin
      phase  = PH_IDLE;
      inject = 1'b0;
    end else if ((wvalid && wready) || (rvalid && rready)) begin
      if (phase == PH_WRITE) begin
        mem[base + beat] = wdata;
      end
      if (beat == 2'd3) begin
        phase = PH_IDLE;
      end
      beat = beat + 1'b1;
    end
    #1;
    // error takes the place of the first data beat
    cready    = phase == PH_IDLE && ($urandom % 4 != 0);
    wready    = phase == PH_WRITE && !inject && ($urandom % 4 != 0);
    rvalid    = phase == PH_READ && !inject && ($urandom % 4 != 0);
    rlast     = beat == 2'd3;
    rdata     = mem[base + beat];
    bus_error = inject && phase != PH_IDLE;
  end

endmodule

//--- verif/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage import dcache_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int SEED = 46971;
  localparam int NUM_REQS = 600;
  localparam int MAX_CYCLES = NUM_REQS * 40;
  localparam int MEM_WORDS = 16384;
  // the line at byte address 0xfc00
  localparam logic [BUS_ADDR_BITS-1:0] ERR_LO = 27'h3f00;
  localparam logic [BUS_ADDR_BITS-1:0] ERR_HI = 27'h3f03;

  logic                     clk_core = 1'b0;
  logic                     reset_n;
  logic                     req_valid;
  logic                     req_ready;
  logic                     req_write;
  logic                     req_extend;
  logic [1:0]               req_width;
  logic [XLEN-1:0]          req_addr;
  logic [XLEN-1:0]          req_wdata;
  logic                     resp_valid;
  logic                     resp_ready = 1'b0;
  logic [XLEN-1:0]          resp_rdata;
  logic                     resp_error;
  logic [3:0]               resp_cause;
  logic                     cvalid;
  logic                     cready;
  logic                     cmd;
  logic [BUS_ADDR_BITS-1:0] bus_addr;
  logic                     wvalid;
  logic                     wready;
  logic                     wlast;
  logic [XLEN-1:0]          wdata;
  logic                     rvalid;
  logic                     rready;
  logic                     rlast;
  logic [XLEN-1:0]          rdata;
  logic                     bus_error;
  logic                     eack;
  logic                     err_en;

  logic [XLEN-1:0] shadow [MEM_WORDS];
  logic            exp_write;
  logic            exp_error;
  logic [3:0]      exp_cause;
  logic [XLEN-1:0] exp_rdata;
  logic [13:0]     wr_base;
  logic [1:0]      wr_beat;
  logic [XLEN-1:0] exp_wdata;
  int              req_count;
  int              cycles = 0;

  // expected cache contents per line
  logic [TAG_BITS-1:0]      line_tag [NUM_LINES];
  logic [NUM_LINES-1:0]     line_valid;
  logic [NUM_LINES-1:0]     line_dirty;
  logic                     exp_evict;
  logic [BUS_ADDR_BITS-1:0] exp_rd_addr;
  logic [BUS_ADDR_BITS-1:0] exp_wr_addr;

  always #(CLK_PERIOD / 2) clk_core = ~clk_core;

  mem_stage dut_i (.*);

  bus_mem_model bus_i (
    .err_lo (ERR_LO),
    .err_hi (ERR_HI),
    .*
  );

  function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] word,
      input logic [1:0] width, input logic ext, input logic [1:0] off);
    logic [XLEN-1:0] shifted;
    shifted = word >> (8 * off);
    case (width)
      WIDTH_BYTE: return ext ? 32'($signed(shifted[7:0])) : 32'(shifted[7:0]);
      WIDTH_HALF: return ext ? 32'($signed(shifted[15:0])) : 32'(shifted[15:0]);
      default: return word;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] store_merge(input logic [XLEN-1:0] old,
      input logic [XLEN-1:0] data, input logic [1:0] width, input logic [1:0] off);
    logic [XLEN-1:0] lanes;
    case (width)
      WIDTH_BYTE: lanes = 32'hff << (8 * off);
      WIDTH_HALF: lanes = 32'hffff << (8 * off);
      default: lanes = 32'hffff_ffff;
    endcase
    return (old & ~lanes) | ((data << (8 * off)) & lanes);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [XLEN-1:0] expected,
      input logic [XLEN-1:0] actual);
    abort_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
  endtask

  // one request from issue to completed response
  task automatic access(input logic wr, input logic ext, input logic [1:0] width,
      input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
    logic [13:0]         widx;
    logic                in_err;
    logic [7:0]          line;
    logic [TAG_BITS-1:0] tag;
    widx        = addr[15:2];
    line        = addr[11:4];
    tag         = addr[28:12];
    in_err      = err_en && addr[28:2] >= ERR_LO && addr[28:2] <= ERR_HI;
    exp_write   = wr;
    exp_error   = in_err;
    exp_cause   = wr ? CAUSE_STORE_FAULT : CAUSE_LOAD_FAULT;
    exp_rdata   = load_value(shadow[widx], width, ext, addr[1:0]);
    exp_evict   = line_valid[line] && line_dirty[line] && line_tag[line] != tag;
    exp_rd_addr = {addr[28:4], 2'b00};
    exp_wr_addr = {line_tag[line], line, 2'b00};
    req_valid   = 1'b1;
    req_write   = wr;
    req_extend  = ext;
    req_width   = width;
    req_addr    = addr;
    req_wdata   = data;
    do begin
      @(posedge clk_core);
    end while (!req_ready);
    #1;
    req_valid = 1'b0;
    do begin
      @(posedge clk_core);
    end while (!(resp_valid && resp_ready));
    if (wr && !in_err) begin
      shadow[widx] = store_merge(shadow[widx], data, width, addr[1:0]);
    end
    if (in_err) begin
      line_valid[line] = 1'b0;
    end else begin
      line_dirty[line] = wr || (line_valid[line] && line_tag[line] == tag
                                && line_dirty[line]);
      line_valid[line] = 1'b1;
      line_tag[line]   = tag;
    end
    req_count++;
    #1;
  endtask

  // write burst position over the expected victim line
  always @(posedge clk_core) begin
    if (cvalid && cready && !cmd) begin
      wr_base <= exp_wr_addr[13:0];
      wr_beat <= '0;
    end else if (wvalid && wready) begin
      wr_beat <= wr_beat + 1'b1;
    end
  end

  assign exp_wdata = shadow[wr_base + wr_beat];

  always begin
    @(posedge clk_core);
    #1;
    resp_ready = ($urandom % 3) != 0;
  end

  always @(posedge clk_core) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      abort_run("timeout: requests did not complete within the cycle limit");
    end
  end

  error_check: assert property (@(posedge clk_core) disable iff (!reset_n)
    resp_valid |-> resp_error == exp_error)
    else value_error("resp_error", exp_error, $sampled(resp_error));

  cause_check: assert property (@(posedge clk_core) disable iff (!reset_n)
    resp_valid && exp_error |-> resp_cause == exp_cause)
    else value_error("resp_cause", exp_cause, $sampled(resp_cause));

  rdata_check: assert property (@(posedge clk_core) disable iff (!reset_n)
    resp_valid && !exp_write && !exp_error |-> resp_rdata == exp_rdata)
    else value_error("resp_rdata", exp_rdata, $sampled(resp_rdata));

  hold_check: assert property (@(posedge clk_core) disable iff (!reset_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata)
      && $stable(resp_error) && $stable(resp_cause))
    else abort_run("response payload changed while resp_ready was low");

  busy_check: assert property (@(posedge clk_core) disable iff (!reset_n)
    resp_valid && !resp_ready |-> !req_ready)
    else abort_run("req_ready went high while a response was stalled");

  cmd_check: assert property (@(posedge clk_core) disable iff (!reset_n)
    cvalid && cready && !cmd |-> exp_evict)
    else abort_run("write burst issued without a dirty victim line");

  addr_check: assert property (@(posedge clk_core) disable iff (!reset_n)
    cvalid && cready |-> bus_addr == (cmd ? exp_rd_addr : exp_wr_addr))
    else value_error("bus_addr", $sampled(cmd) ? exp_rd_addr : exp_wr_addr,
                     $sampled(bus_addr));

  wdata_check: assert property (@(posedge clk_core) disable iff (!reset_n)
    wvalid && wready |-> wdata == exp_wdata)
    else value_error("wdata", $sampled(exp_wdata), $sampled(wdata));

  wlast_check: assert property (@(posedge clk_core) disable iff (!reset_n)
    wvalid |-> wlast == (wr_beat == 2'd3))
    else value_error("wlast", $sampled(wr_beat == 2'd3), $sampled(wlast));

  eack_check: assert property (@(posedge clk_core) disable iff (!reset_n)
    eack == bus_error)
    else value_error("eack", $sampled(bus_error), $sampled(eack));

  initial begin
    logic [XLEN-1:0] addr;
    logic [1:0]      width;
    void'($urandom(SEED));
    reset_n    = 1'b0;
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_extend = 1'b0;
    req_width  = WIDTH_WORD;
    req_addr   = '0;
    req_wdata  = '0;
    err_en     = 1'b0;
    req_count  = 0;
    line_valid = '0;
    line_dirty = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = 32'(i * 4) ^ 32'ha5a5a5a5;
    end
    repeat (10) @(posedge clk_core);
    #1;
    reset_n = 1'b1;

    // cold miss, then a hit
    access(1'b0, 1'b0, WIDTH_WORD, 32'h0000_0100, '0);
    access(1'b0, 1'b0, WIDTH_WORD, 32'h0000_0100, '0);
    for (int off = 0; off < 4; off++) begin
      for (int ext = 0; ext < 2; ext++) begin
        access(1'b0, 1'(ext), WIDTH_BYTE, 32'h0000_0100 + off, '0);
        if (off % 2 == 0) begin
          access(1'b0, 1'(ext), WIDTH_HALF, 32'h0000_0100 + off, '0);
        end
      end
    end
    // narrow stores merged into cached words
    access(1'b1, 1'b0, WIDTH_BYTE, 32'h0000_0105, 32'h0000_0037);
    access(1'b0, 1'b0, WIDTH_WORD, 32'h0000_0104, '0);
    access(1'b1, 1'b0, WIDTH_HALF, 32'h0000_010a, 32'h0000_8123);
    access(1'b0, 1'b0, WIDTH_WORD, 32'h0000_0108, '0);
    access(1'b1, 1'b0, WIDTH_WORD, 32'h0000_010c, 32'h1357_9bdf);
    access(1'b0, 1'b0, WIDTH_WORD, 32'h0000_010c, '0);
    // new tag on the dirty set forces a write burst
    access(1'b0, 1'b0, WIDTH_WORD, 32'h0000_1100, '0);
    access(1'b0, 1'b0, WIDTH_WORD, 32'h0000_0108, '0);
    // faults first, then a normal refill of the same line
    err_en = 1'b1;
    access(1'b0, 1'b0, WIDTH_WORD, 32'h0000_fc04, '0);
    access(1'b1, 1'b0, WIDTH_WORD, 32'h0000_fc08, 32'h2468_ace0);
    err_en = 1'b0;
    access(1'b0, 1'b0, WIDTH_WORD, 32'h0000_fc08, '0);

    // four tags over sixteen sets
    while (req_count < NUM_REQS) begin
      width = 2'($urandom % 3);
      addr  = $urandom & 32'h0000_30ff;
      if (width == WIDTH_HALF) begin
        addr[0] = 1'b0;
      end
      if (width == WIDTH_WORD) begin
        addr[1:0] = 2'b00;
      end
      access(1'($urandom % 2), 1'($urandom % 2), width, addr, $urandom);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- src.f
design/dcache_pkg.sv
design/lane_align.sv
design/dcache_array.sv
design/refill_ctrl.sv
design/mem_stage.sv
verif/bus_mem_model.sv
verif/tb_mem_stage.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - design/dcache_pkg.sv
  - design/lane_align.sv
  - design/dcache_array.sv
  - design/refill_ctrl.sv
  - design/mem_stage.sv
  - target: test
    files:
      - verif/bus_mem_model.sv
      - verif/tb_mem_stage.sv
